/* design/wbPkg.sv */
// shared widths and limits for the first-layer writeback path
// five terms of 19 bits fit in 22 bits without overflow
`default_nettype none

package wbPkg;

    // signed partial sum from one processing element
    typedef logic signed [18:0] PartialSum_t;

    // total of NumTerms partial sums
    typedef logic signed [21:0] ChannelSum_t;

    // saturated output feature value
    typedef logic signed [7:0] Pixel_t;

    // one BRAM word, eight pixels, first pixel in the top byte
    typedef logic [63:0] BramWord_t;

    // BRAM word address, wraps at 12 bits
    typedef logic [11:0] BramAddr_t;

    localparam int NumTerms = 5;     // partial sums per lane
    localparam int BytesPerWord = 8; // pixels per BRAM word

    // saturation limits of a signed byte
    localparam int PixelMax = 127;
    localparam int PixelMin = -128;

endpackage

`default_nettype wire

/* design/sumSaturate.sv */
// one lane: adds NumTerms partial sums, shifts right by Shift, clamps to a signed byte
// output registered one cycle after sumValid, new sum accepted every cycle
`timescale 1ns/1ps
`default_nettype none

module sumSaturate #(
    parameter int unsigned Shift = 9
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          sumValid,
    input  wbPkg::PartialSum_t [wbPkg::NumTerms-1:0]      sums,
    output wbPkg::Pixel_t                                 pixel,
    output logic                                          pixelValid
);

    wbPkg::ChannelSum_t total;
    wbPkg::ChannelSum_t shifted;
    wbPkg::Pixel_t      clamped;

    // sign-extend every term before adding
    always_comb begin
        total = '0;
        for (int i = 0; i < wbPkg::NumTerms; i++) begin
            total = total + wbPkg::ChannelSum_t'(sums[i]);
        end
    end

    assign shifted = total >>> Shift; // floor division by 2^Shift

    always_comb begin
        if (shifted > wbPkg::ChannelSum_t'(wbPkg::PixelMax)) begin
            clamped = wbPkg::Pixel_t'(wbPkg::PixelMax);
        end else if (shifted < wbPkg::ChannelSum_t'(wbPkg::PixelMin)) begin
            clamped = wbPkg::Pixel_t'(wbPkg::PixelMin);
        end else begin
            clamped = shifted[7:0]; // already in byte range
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= sumValid;
        end
    end

    // pixel only meaningful with pixelValid
    always_ff @(posedge clk) begin
        if (sumValid) begin
            pixel <= clamped;
        end
    end

endmodule

`default_nettype wire

/* design/wordPacker.sv */
// packs eight pixels per lane MSB-first into 64-bit words, lanes share one byte position
// pixelValid of lane A qualifies both lanes; low wbEnable drops a partial word
`timescale 1ns/1ps
`default_nettype none

module wordPacker (
    input  logic             clk,
    input  logic             rst,
    input  logic             wbEnable,
    input  logic             pixelValid,
    input  wbPkg::Pixel_t    pixelA,
    input  wbPkg::Pixel_t    pixelB,
    output wbPkg::BramWord_t wordA,
    output wbPkg::BramWord_t wordB,
    output logic             wordValid
);

    localparam int PosW = $clog2(wbPkg::BytesPerWord);
    localparam logic [PosW-1:0] LastPos = PosW'(wbPkg::BytesPerWord - 1);

    logic [PosW-1:0]  bytePos;   // count of pixels gathered so far
    wbPkg::BramWord_t accA;
    wbPkg::BramWord_t accB;
    wbPkg::BramWord_t nextA;
    wbPkg::BramWord_t nextB;
    logic             accept;

    // k-th pixel goes to byte 7-k
    function automatic wbPkg::BramWord_t placeByte(
        input wbPkg::BramWord_t word,
        input logic [PosW-1:0]  pos,
        input wbPkg::Pixel_t    px
    );
        wbPkg::BramWord_t w;
        w = word;
        w[(LastPos - pos) * 8 +: 8] = px;
        return w;
    endfunction

    assign accept = pixelValid && wbEnable;
    assign nextA  = placeByte(accA, bytePos, pixelA);
    assign nextB  = placeByte(accB, bytePos, pixelB);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bytePos   <= '0;
            accA      <= '0;
            accB      <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            if (!wbEnable) begin
                bytePos <= '0; // partial word discarded
                accA    <= '0;
                accB    <= '0;
            end else if (accept) begin
                if (bytePos == LastPos) begin
                    bytePos   <= '0;
                    accA      <= '0;
                    accB      <= '0;
                    wordValid <= 1'b1;
                end else begin
                    bytePos <= bytePos + 1'b1;
                    accA    <= nextA;
                    accB    <= nextB;
                end
            end
        end
    end

    // finished words, valid with wordValid
    always_ff @(posedge clk) begin
        if (accept && bytePos == LastPos) begin
            wordA <= nextA;
            wordB <= nextB;
        end
    end

endmodule

`default_nettype wire

/* design/bramAddrGen.sv */
// forms both lane addresses from rowBase + wordIndex and registers the BRAM write
// nextRow must not coincide with wordValid; addresses wrap at 12 bits
`timescale 1ns/1ps
`default_nettype none

module bramAddrGen #(
    parameter wbPkg::BramAddr_t BankOffset = 128,
    parameter wbPkg::BramAddr_t RowStride  = 128
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wordValid,
    input  wbPkg::BramWord_t wordA,
    input  wbPkg::BramWord_t wordB,
    input  logic             nextRow,
    output logic             bramWe,
    output wbPkg::BramAddr_t bramAddrA,
    output wbPkg::BramAddr_t bramAddrB,
    output wbPkg::BramWord_t bramDinA,
    output wbPkg::BramWord_t bramDinB
);

    wbPkg::BramAddr_t rowBase;   // first word of the current row
    wbPkg::BramAddr_t wordIndex; // words written in this row
    wbPkg::BramAddr_t laneAddr;

    assign laneAddr = rowBase + wordIndex;

    // address registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rowBase   <= '0;
            wordIndex <= '0;
        end else begin
            if (nextRow) begin
                rowBase   <= rowBase + RowStride;
                wordIndex <= '0;
            end else if (wordValid) begin
                wordIndex <= wordIndex + 1'b1;
            end
        end
    end

    // registered write port toward the BRAM
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bramWe    <= 1'b0;
            bramAddrA <= '0;
            bramAddrB <= '0;
            bramDinA  <= '0;
            bramDinB  <= '0;
        end else begin
            bramWe <= wordValid; // one cycle per word
            if (wordValid) begin
                bramAddrA <= laneAddr;
                bramAddrB <= laneAddr + BankOffset; // lane B bank
                bramDinA  <= wordA;
                bramDinB  <= wordB;
            end
        end
    end

endmodule

`default_nettype wire

/* design/featureWriteback.sv */
// first-layer writeback: two saturating lanes, word packer and BRAM address generator
// no back-pressure, BRAM write lands 3 cycles after the eighth accepted sumValid
`timescale 1ns/1ps
`default_nettype none

module featureWriteback #(
    parameter int unsigned      Shift      = 9,
    parameter wbPkg::BramAddr_t BankOffset = 128,
    parameter wbPkg::BramAddr_t RowStride  = 128
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     sumValid,
    input  wbPkg::PartialSum_t [wbPkg::NumTerms-1:0] sumsA,
    input  wbPkg::PartialSum_t [wbPkg::NumTerms-1:0] sumsB,
    input  logic                                     wbEnable,
    input  logic                                     nextRow,
    output logic                                     bramWe,
    output wbPkg::BramAddr_t                         bramAddrA,
    output wbPkg::BramAddr_t                         bramAddrB,
    output wbPkg::BramWord_t                         bramDinA,
    output wbPkg::BramWord_t                         bramDinB
);

    wbPkg::Pixel_t    pixelA;
    wbPkg::Pixel_t    pixelB;
    logic             pixelValid;
    wbPkg::BramWord_t wordA;
    wbPkg::BramWord_t wordB;
    logic             wordValid;

    sumSaturate #(
        .Shift(Shift)
    ) laneA (
        .clk       (clk),
        .rst       (rst),
        .sumValid  (sumValid),
        .sums      (sumsA),
        .pixel     (pixelA),
        .pixelValid(pixelValid)
    );

    // strobes in step with lane A, its valid is not needed
    sumSaturate #(
        .Shift(Shift)
    ) laneB (
        .clk       (clk),
        .rst       (rst),
        .sumValid  (sumValid),
        .sums      (sumsB),
        .pixel     (pixelB),
        .pixelValid()
    );

    wordPacker packer (
        .clk       (clk),
        .rst       (rst),
        .wbEnable  (wbEnable),
        .pixelValid(pixelValid),
        .pixelA    (pixelA),
        .pixelB    (pixelB),
        .wordA     (wordA),
        .wordB     (wordB),
        .wordValid (wordValid)
    );

    bramAddrGen #(
        .BankOffset(BankOffset),
        .RowStride (RowStride)
    ) addrGen (
        .clk      (clk),
        .rst      (rst),
        .wordValid(wordValid),
        .wordA    (wordA),
        .wordB    (wordB),
        .nextRow  (nextRow),
        .bramWe   (bramWe),
        .bramAddrA(bramAddrA),
        .bramAddrB(bramAddrB),
        .bramDinA (bramDinA),
        .bramDinB (bramDinB)
    );

endmodule

`default_nettype wire

/* verif/featureWriteback_chk.sv */
// assertions bound into featureWriteback: write strobe during reset, strobe width, lane B offset
// lane offset is only checked on a write, address outputs idle at 0 after reset
`timescale 1ns/1ps
`default_nettype none

module featureWriteback_chk #(
    parameter wbPkg::BramAddr_t BankOffset = 128
) (
    input logic             clk,
    input logic             rst,
    input logic             bramWe,
    input wbPkg::BramAddr_t bramAddrA,
    input wbPkg::BramAddr_t bramAddrB
);

    // async reset clears the strobe
    resetClearsWe: assert property (@(posedge clk) !rst |-> !bramWe)
        else $error("bramWe high while reset is asserted");

    singleCycleWe: assert property (@(posedge clk) disable iff (!rst) bramWe |=> !bramWe)
        else $error("bramWe stayed high for two cycles in a row");

    laneOffset: assert property (@(posedge clk) disable iff (!rst)
        bramWe |-> bramAddrB == wbPkg::BramAddr_t'(bramAddrA + BankOffset))
        else $error("bramAddrB is not bramAddrA plus the bank offset");

endmodule

bind featureWriteback featureWriteback_chk #(
    .BankOffset(BankOffset)
) chk (
    .clk      (clk),
    .rst      (rst),
    .bramWe   (bramWe),
    .bramAddrA(bramAddrA),
    .bramAddrB(bramAddrB)
);

`default_nettype wire

/* verif/featureWriteback_tb.sv */
// random partial sums from a fixed LCG seed checked against a cycle model of the writeback path
// nextRow is only issued with no word in flight
`timescale 1ns/1ps
`default_nettype none

module featureWriteback_tb;

    localparam int Shift        = 9;
    localparam int BankOffset   = 128;
    localparam int RowStride    = 128;
    localparam int ClkPeriod    = 20;
    localparam int Scale        = 1 << Shift;
    localparam int AddrSpace    = 1 << $bits(wbPkg::BramAddr_t);
    localparam int TermMax      = (1 << ($bits(wbPkg::PartialSum_t) - 1)) - 1;
    localparam int TermMin      = -TermMax - 1;
    localparam int BurstWords   = 6;
    localparam int RandomPixels = 64;
    localparam int SkipRows     = 29; // brings rowBase to the top row of the 12-bit space

    // upper bound on stimulus length with at most 3 idle cycles per gap
    localparam int StimCycles = 6 + BurstWords * 8 + RandomPixels * 4 + 8 + 3 * 6 + 20
                              + 3 * 2 * 8 + 5 + 2 * SkipRows + 6;
    localparam int WatchdogCycles = StimCycles + 50;

    logic                                     clk;
    logic                                     rst;
    logic                                     sumValid;
    wbPkg::PartialSum_t [wbPkg::NumTerms-1:0] sumsA;
    wbPkg::PartialSum_t [wbPkg::NumTerms-1:0] sumsB;
    logic                                     wbEnable;
    logic                                     nextRow;
    logic                                     bramWe;
    wbPkg::BramAddr_t                         bramAddrA;
    wbPkg::BramAddr_t                         bramAddrB;
    wbPkg::BramWord_t                         bramDinA;
    wbPkg::BramWord_t                         bramDinB;

    logic [31:0] seed = 32'h3ef9_0de8;
    int          cycleCount = 0;
    int          writesSeen = 0;

    // model state
    int          bytePos = 0;
    int          rowBase = 0;
    int          wordIndex = 0;
    logic [63:0] accA = '0;
    logic [63:0] accB = '0;
    logic        prevValid = 1'b0;
    logic [7:0]  prevPixA = '0;
    logic [7:0]  prevPixB = '0;

    // expected writes in arrival order
    logic [63:0] expDinA[$];
    logic [63:0] expDinB[$];
    int          expAddrA[$];
    int          expAddrB[$];
    int          expCycle[$];

    featureWriteback #(
        .Shift     (Shift),
        .BankOffset(BankOffset),
        .RowStride (RowStride)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .sumValid (sumValid),
        .sumsA    (sumsA),
        .sumsB    (sumsB),
        .wbEnable (wbEnable),
        .nextRow  (nextRow),
        .bramWe   (bramWe),
        .bramAddrA(bramAddrA),
        .bramAddrB(bramAddrB),
        .bramDinA (bramDinA),
        .bramDinB (bramDinB)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // mode 0 extremes, 1 full range, else small terms that land near the byte range
    function automatic int randomTerm(input int mode);
        logic [31:0] r;
        r = nextRand();
        case (mode)
            0:       return r[31] ? TermMax : TermMin;
            1:       return int'($signed(r[30:12]));
            default: return int'($signed(r[30:16]));
        endcase
    endfunction

    // floor(total / 2^Shift) clamped to a signed byte
    function automatic logic [7:0] expectPixel(input int total);
        int q;
        if (total >= 0) begin
            q = total / Scale;
        end else begin
            q = -((-total + Scale - 1) / Scale);
        end
        if (q > wbPkg::PixelMax) begin
            q = wbPkg::PixelMax;
        end else if (q < wbPkg::PixelMin) begin
            q = wbPkg::PixelMin;
        end
        return q[7:0];
    endfunction

    task automatic stopWithFailure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    // packer and address rule for the pixel strobed in the previous cycle
    task automatic packModel(input logic enable);
        int addr;
        if (!enable) begin
            bytePos = 0; // partial word dropped
            accA    = '0;
            accB    = '0;
        end else if (prevValid) begin
            accA[(wbPkg::BytesPerWord - 1 - bytePos) * 8 +: 8] = prevPixA;
            accB[(wbPkg::BytesPerWord - 1 - bytePos) * 8 +: 8] = prevPixB;
            if (bytePos == wbPkg::BytesPerWord - 1) begin
                addr = (rowBase + wordIndex) % AddrSpace;
                expDinA.push_back(accA);
                expDinB.push_back(accB);
                expAddrA.push_back(addr);
                expAddrB.push_back((addr + BankOffset) % AddrSpace);
                expCycle.push_back(cycleCount + 2);
                wordIndex = wordIndex + 1;
                bytePos   = 0;
                accA      = '0;
                accB      = '0;
            end else begin
                bytePos = bytePos + 1;
            end
        end
    endtask

    // one clock of stimulus followed by the model step for that cycle
    task automatic stepCycle(input logic valid, input logic enable, input logic row);
        int          i;
        int          termA;
        int          termB;
        int          totA;
        int          totB;
        logic [31:0] r;
        @(posedge clk);
        #1;
        r    = nextRand();
        totA = 0;
        totB = 0;
        for (i = 0; i < wbPkg::NumTerms; i++) begin
            termA    = randomTerm(int'(r[31:30]));
            termB    = randomTerm(int'(r[29:28]));
            sumsA[i] = wbPkg::PartialSum_t'(termA);
            sumsB[i] = wbPkg::PartialSum_t'(termB);
            totA     = totA + termA;
            totB     = totB + termB;
        end
        sumValid = valid;
        wbEnable = enable;
        nextRow  = row;
        packModel(enable);
        if (row) begin
            rowBase   = (rowBase + RowStride) % AddrSpace;
            wordIndex = 0;
        end
        prevValid = valid;
        prevPixA  = expectPixel(totA);
        prevPixB  = expectPixel(totB);
    endtask

    task automatic sendWords(input int n);
        repeat (n * wbPkg::BytesPerWord) stepCycle(1'b1, 1'b1, 1'b0);
    endtask

    // strobes until the word in progress is complete
    task automatic finishWord();
        while ((bytePos + (prevValid ? 1 : 0)) % wbPkg::BytesPerWord != 0) begin
            stepCycle(1'b1, 1'b1, 1'b0);
        end
    endtask

    task automatic randomPixels(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = nextRand();
            if (r[31:30] == 2'd0) begin
                repeat (1 + int'(r[29:28]) % 3) stepCycle(1'b0, 1'b1, 1'b0);
            end
            stepCycle(1'b1, 1'b1, 1'b0);
        end
        finishWord();
    endtask

    // lets any word drain before the row strobe
    task automatic advanceRow();
        repeat (5) stepCycle(1'b0, 1'b1, 1'b0);
        stepCycle(1'b0, 1'b1, 1'b1);
    endtask

    // last word drains before the first row strobe
    task automatic skipRows(input int n);
        repeat (5) stepCycle(1'b0, 1'b1, 1'b0);
        repeat (n) begin
            stepCycle(1'b0, 1'b1, 1'b1);
            stepCycle(1'b0, 1'b1, 1'b0);
        end
    endtask

    task automatic enableDrop();
        repeat (3) stepCycle(1'b1, 1'b1, 1'b0);
        stepCycle(1'b1, 1'b0, 1'b0);
        stepCycle(1'b0, 1'b0, 1'b0);
        stepCycle(1'b1, 1'b0, 1'b0); // accepted once wbEnable is back
        stepCycle(1'b1, 1'b1, 1'b0);
        finishWord();
    endtask

    task automatic checkWrite();
        if (expDinA.size() == 0) begin
            $display("BRAM write at %0t while no write was expected", $time);
            stopWithFailure();
        end else begin
            compareValue("write cycle", cycleCount, expCycle.pop_front());
            compareValue("bramDinA", bramDinA, expDinA.pop_front());
            compareValue("bramDinB", bramDinB, expDinB.pop_front());
            compareValue("bramAddrA", bramAddrA, expAddrA.pop_front());
            compareValue("bramAddrB", bramAddrB, expAddrB.pop_front());
            writesSeen = writesSeen + 1;
        end
    endtask

    // outputs settle after the rising edge and are sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b1) begin
            if ($isunknown(bramWe)) begin
                $display("bramWe is unknown at %0t after reset", $time);
                stopWithFailure();
            end else if (bramWe) begin
                checkWrite();
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: stimulus did not finish within %0d cycles", WatchdogCycles);
        stopWithFailure();
    end

    initial begin
        rst      = 1'b1;
        sumValid = 1'b0;
        sumsA    = '0;
        sumsB    = '0;
        wbEnable = 1'b0;
        nextRow  = 1'b0;
        #2;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        compareValue("bramWe", bramWe, 64'd0);

        sendWords(BurstWords); // no gaps between strobes
        randomPixels(RandomPixels);
        advanceRow();
        enableDrop();
        advanceRow();
        sendWords(2);
        skipRows(SkipRows);
        sendWords(2); // lane B wraps past 4095
        advanceRow();
        sendWords(2); // rowBase wraps to 0
        repeat (6) stepCycle(1'b0, 1'b1, 1'b0);

        if (expDinA.size() != 0) begin
            $display("%0d expected BRAM writes never happened", expDinA.size());
            stopWithFailure();
        end else begin
            $display("checked %0d BRAM writes", writesSeen);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
design/wbPkg.sv
design/sumSaturate.sv
design/wordPacker.sv
design/bramAddrGen.sv
design/featureWriteback.sv
verif/featureWriteback_chk.sv
verif/featureWriteback_tb.sv
